// ==== Bender.yml ====
package:
  name: dma_engine

sources:
  - rtl/dma_bus_pkg.sv
  - rtl/dma_xfer_pkg.sv
  - rtl/cpu_bus_sync.sv
  - rtl/dma_fifo.sv
  - rtl/dma_addr_cnt.sv
  - rtl/cpu_sm.sv
  - rtl/dma_top.sv
  - target: simulation
    files:
      - test/tb_dma_checker.sv
      - test/tb_dma_top.sv

// ==== rtl/cpu_bus_sync.sv ====
// synchronizers for the asynchronous bus and control inputs
// every input shows up SYNC_STAGES clocks after it changes
`timescale 1ns/1ps

module cpu_bus_sync (
    input  logic               BCLK,
    input  logic               CCRESET_,
    input  logic               bg_async,
    input  dma_bus_pkg::term_t dsack_async,
    input  logic               sterm_async,
    input  logic               ena_async,
    input  logic               flush_async,
    output logic               bg_,
    output dma_bus_pkg::term_t dsack_,
    output logic               sterm_,
    output logic               dma_ena,
    output logic               flush_req
);
    import dma_xfer_pkg::*;

    // {bg_, dsack_[1:0], sterm_, ena, flush}
    logic [5:0] stage [SYNC_STAGES];

    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            // active-low strobes come out of reset negated
            for (int i = 0; i < SYNC_STAGES; i++) begin
                stage[i] <= 6'b111100;
            end
        end else begin
            stage[0] <= {bg_async, dsack_async, sterm_async, ena_async, flush_async};
            for (int i = 1; i < SYNC_STAGES; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign {bg_, dsack_, sterm_, dma_ena, flush_req} = stage[SYNC_STAGES-1];

endmodule

// ==== rtl/cpu_sm.sv ====
// bus master FSM: arbitration and memory write cycles with dynamic sizing
// all bus inputs are expected already synchronized to BCLK
`timescale 1ns/1ps

module cpu_sm (
    input  logic                    BCLK,
    input  logic                    CCRESET_,
    input  logic                    dma_ena,
    input  logic                    flush_req,
    input  dma_xfer_pkg::fifo_cnt_t fifo_count,
    input  dma_bus_pkg::bus_data_t  fifo_data,
    input  dma_bus_pkg::bus_addr_t  word_addr,
    input  dma_xfer_pkg::word_cnt_t remaining,
    input  logic                    last,
    input  logic                    bg_,
    input  dma_bus_pkg::term_t      dsack_,
    input  logic                    sterm_,
    output logic                    br,
    output logic                    bgack,
    output logic                    as,
    output logic                    ds,
    output dma_bus_pkg::bus_addr_t  addr,
    output dma_bus_pkg::bus_data_t  data_out,
    output logic                    pop,
    output logic                    advance,
    output logic                    stop_flush,
    output logic                    done
);
    import dma_bus_pkg::*;
    import dma_xfer_pkg::*;

    bus_state_t state;
    logic       armed;
    logic       term_idle;
    logic       term_hit;
    logic       term_16;
    logic       start_ok;
    logic       more_ok;

    // a termination counts only after the bus has been seen idle in this strobe,
    // the synced dsack_ of the previous cycle lingers for a few clocks
    assign term_idle = sterm_ && (dsack_ == TERM_WAIT);
    assign term_hit  = as && armed &&
                       (!sterm_ || dsack_ == TERM_32 || dsack_ == TERM_16);
    assign term_16   = sterm_ && (dsack_ == TERM_16);

    assign start_ok = dma_ena && (remaining != '0) &&
                      ((fifo_count >= fifo_cnt_t'(BURST_THRESH)) ||
                       (flush_req && fifo_count != '0) ||
                       (word_cnt_t'(fifo_count) >= remaining));
    assign more_ok  = dma_ena && (remaining != '0) && (fifo_count != '0);

    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            state      <= IDLE;
            br         <= 1'b0;
            bgack      <= 1'b0;
            as         <= 1'b0;
            ds         <= 1'b0;
            armed      <= 1'b0;
            pop        <= 1'b0;
            advance    <= 1'b0;
            stop_flush <= 1'b0;
            done       <= 1'b0;
        end else begin
            pop        <= 1'b0;
            advance    <= 1'b0;
            stop_flush <= 1'b0;
            if (as && term_idle) begin
                armed <= 1'b1;
            end
            // counter hits zero on the edge that ends this cycle
            if (advance && last) begin
                done <= 1'b1;
            end else if (remaining != '0) begin
                done <= 1'b0;
            end
            case (state)
                IDLE: begin
                    if (start_ok) begin
                        br    <= 1'b1;
                        state <= REQ;
                    end
                end
                REQ: begin
                    if (!bg_) begin
                        br    <= 1'b0;
                        bgack <= 1'b1;
                        state <= GRANTED;
                    end
                end
                GRANTED: begin
                    if (more_ok) begin
                        as    <= 1'b1;
                        ds    <= 1'b1;
                        armed <= 1'b0;
                        state <= STROBE;
                    end else begin
                        bgack      <= 1'b0;
                        stop_flush <= flush_req && (fifo_count == '0);
                        state      <= IDLE;
                    end
                end
                STROBE: begin
                    if (term_hit) begin
                        as <= 1'b0;
                        ds <= 1'b0;
                        if (term_16) begin
                            state <= HALF2;
                        end else begin
                            pop     <= 1'b1;
                            advance <= 1'b1;
                            state   <= RELEASE;
                        end
                    end
                end
                HALF2: begin
                    // one idle clock, then the low half as a second cycle
                    if (!as) begin
                        as    <= 1'b1;
                        ds    <= 1'b1;
                        armed <= 1'b0;
                    end else if (term_hit) begin
                        as      <= 1'b0;
                        ds      <= 1'b0;
                        pop     <= 1'b1;
                        advance <= 1'b1;
                        state   <= RELEASE;
                    end
                end
                RELEASE: begin
                    // FIFO head and counter settle before the next decision
                    state <= GRANTED;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // address and data launch with the strobes
    always_ff @(posedge BCLK) begin
        if (state == GRANTED && more_ok) begin
            addr     <= word_addr;
            data_out <= fifo_data;
        end else if (state == HALF2 && !as) begin
            addr     <= word_addr + HALF_OFFSET;
            // 16-bit port reads the upper lanes, lower lanes get a copy
            data_out <= {fifo_data[15:0], fifo_data[15:0]};
        end
    end

    a_as_needs_bgack: assert property (
        @(posedge BCLK) disable iff (!CCRESET_)
        as |-> bgack
    );

endmodule

// ==== rtl/dma_addr_cnt.sv ====
// address and remaining-word counter for one transfer
// addresses advance by a full word; load wins over advance
`timescale 1ns/1ps

module dma_addr_cnt (
    input  logic                    BCLK,
    input  logic                    CCRESET_,
    input  logic                    load,
    input  dma_bus_pkg::bus_addr_t  start_addr,
    input  dma_xfer_pkg::word_cnt_t word_count,
    input  logic                    advance,
    output dma_bus_pkg::bus_addr_t  addr,
    output dma_xfer_pkg::word_cnt_t remaining,
    output logic                    last
);
    import dma_bus_pkg::*;
    import dma_xfer_pkg::*;

    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            addr      <= '0;
            remaining <= '0;
        end else if (load) begin
            addr      <= start_addr;
            remaining <= word_count;
        end else if (advance) begin
            addr      <= addr + WORD_BYTES;
            remaining <= remaining - 1'b1;
        end
    end

    assign last = (remaining == word_cnt_t'(1));

    // the bus master stops before the count runs out
    a_no_advance_empty: assert property (
        @(posedge BCLK) disable iff (!CCRESET_)
        advance |-> remaining != '0
    );

endmodule

// ==== rtl/dma_bus_pkg.sv ====
// definitions for the 68030-style asynchronous system bus
// dsack_ and sterm_ are active low; byte-wide ports are not supported
package dma_bus_pkg;

    // byte address and data word as seen on the bus
    typedef logic [31:0] bus_addr_t;
    typedef logic [31:0] bus_data_t;

    // synchronized dsack_ pair, bit 1 is dsack1_
    typedef logic [1:0] term_t;

    localparam term_t TERM_32   = 2'b00;
    localparam term_t TERM_16   = 2'b01;
    localparam term_t TERM_WAIT = 2'b11;

    // address steps for a full word and for the second half on a 16-bit port
    localparam bus_addr_t WORD_BYTES  = 32'd4;
    localparam bus_addr_t HALF_OFFSET = 32'd2;

    typedef enum logic [2:0] {
        IDLE,
        REQ,
        GRANTED,
        STROBE,
        HALF2,
        RELEASE
    } bus_state_t;

endpackage

// ==== rtl/dma_fifo.sv ====
// word FIFO from the device side to the bus master
// the producer holds FIFO_DEPTH credits, so push never meets a full FIFO
`timescale 1ns/1ps

module dma_fifo (
    input  logic                    BCLK,
    input  logic                    CCRESET_,
    input  logic                    push,
    input  dma_bus_pkg::bus_data_t  wdata,
    input  logic                    pop,
    output dma_bus_pkg::bus_data_t  rdata,
    output dma_xfer_pkg::fifo_cnt_t count,
    output logic                    credit
);
    import dma_bus_pkg::*;
    import dma_xfer_pkg::*;

    bus_data_t                       mem [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0]   rd_ptr;

    always_ff @(posedge BCLK) begin
        if (push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            // one credit goes back for every word that leaves
            credit <= pop;
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // head word, valid once count is nonzero
    assign rdata = mem[rd_ptr];

    // device must honour its credits
    a_no_push_full: assert property (
        @(posedge BCLK) disable iff (!CCRESET_)
        push && !pop |-> count != fifo_cnt_t'(FIFO_DEPTH)
    );

    // bus master only pops a word it has seen
    a_no_pop_empty: assert property (
        @(posedge BCLK) disable iff (!CCRESET_)
        pop |-> count != '0
    );

endmodule

// ==== rtl/dma_top.sv ====
// device-to-memory DMA engine, device words in, 68030-style bus writes out
// dma_ena, flush, bg_, dsack_ and sterm_ may change at any time
`timescale 1ns/1ps

module dma_top (
    input  logic                    BCLK,
    input  logic                    CCRESET_,
    input  logic                    load,
    input  dma_bus_pkg::bus_addr_t  start_addr,
    input  dma_xfer_pkg::word_cnt_t word_count,
    input  logic                    dma_ena,
    input  logic                    flush,
    input  logic                    dev_valid,
    input  dma_bus_pkg::bus_data_t  dev_data,
    output logic                    dev_credit,
    output logic                    br,
    input  logic                    bg_,
    output logic                    bgack,
    output logic                    as,
    output logic                    ds,
    output dma_bus_pkg::bus_addr_t  addr,
    output dma_bus_pkg::bus_data_t  data_out,
    input  dma_bus_pkg::term_t      dsack_,
    input  logic                    sterm_,
    output logic                    stop_flush,
    output logic                    done
);
    import dma_bus_pkg::*;
    import dma_xfer_pkg::*;

    logic      bg_sync_;
    term_t     dsack_sync_;
    logic      sterm_sync_;
    logic      ena_sync;
    logic      flush_sync;
    bus_data_t fifo_data;
    fifo_cnt_t fifo_count;
    bus_addr_t word_addr;
    word_cnt_t remaining;
    logic      last;
    logic      pop;
    logic      advance;

    cpu_bus_sync u_sync (
        .BCLK        (BCLK),
        .CCRESET_    (CCRESET_),
        .bg_async    (bg_),
        .dsack_async (dsack_),
        .sterm_async (sterm_),
        .ena_async   (dma_ena),
        .flush_async (flush),
        .bg_         (bg_sync_),
        .dsack_      (dsack_sync_),
        .sterm_      (sterm_sync_),
        .dma_ena     (ena_sync),
        .flush_req   (flush_sync)
    );

    dma_fifo u_fifo (
        .BCLK     (BCLK),
        .CCRESET_ (CCRESET_),
        .push     (dev_valid),
        .wdata    (dev_data),
        .pop      (pop),
        .rdata    (fifo_data),
        .count    (fifo_count),
        .credit   (dev_credit)
    );

    dma_addr_cnt u_cnt (
        .BCLK       (BCLK),
        .CCRESET_   (CCRESET_),
        .load       (load),
        .start_addr (start_addr),
        .word_count (word_count),
        .advance    (advance),
        .addr       (word_addr),
        .remaining  (remaining),
        .last       (last)
    );

    cpu_sm u_sm (
        .BCLK       (BCLK),
        .CCRESET_   (CCRESET_),
        .dma_ena    (ena_sync),
        .flush_req  (flush_sync),
        .fifo_count (fifo_count),
        .fifo_data  (fifo_data),
        .word_addr  (word_addr),
        .remaining  (remaining),
        .last       (last),
        .bg_        (bg_sync_),
        .dsack_     (dsack_sync_),
        .sterm_     (sterm_sync_),
        .br         (br),
        .bgack      (bgack),
        .as         (as),
        .ds         (ds),
        .addr       (addr),
        .data_out   (data_out),
        .pop        (pop),
        .advance    (advance),
        .stop_flush (stop_flush),
        .done       (done)
    );

endmodule

// ==== rtl/dma_xfer_pkg.sv ====
// transfer sizing for the device-to-memory path
// FIFO_DEPTH must be a power of two and fit in fifo_cnt_t
package dma_xfer_pkg;

    // word FIFO between the device producer and the bus master
    localparam int FIFO_DEPTH = 8;

    // occupancy, 0 up to FIFO_DEPTH inclusive
    typedef logic [3:0] fifo_cnt_t;

    // words still to be written in the current transfer
    typedef logic [15:0] word_cnt_t;

    // fill level that justifies asking for the bus without a flush
    localparam int BURST_THRESH = 4;

    // flops per asynchronous input
    localparam int SYNC_STAGES = 2;

endpackage

// ==== test/tb_dma_checker.sv ====
// compares every bus write with the device words pushed since the last clear
// a 16-bit port is only checked on the upper data lanes
`timescale 1ns/1ps

module tb_dma_checker (
    input  logic                   BCLK,
    input  logic                   CCRESET_,
    input  logic                   dev_valid,
    input  dma_bus_pkg::bus_data_t dev_data,
    input  logic                   dev_credit,
    input  logic                   br,
    input  logic                   bgack,
    input  logic                   as,
    input  logic                   ds,
    input  dma_bus_pkg::bus_addr_t addr,
    input  dma_bus_pkg::bus_data_t data_out,
    input  logic                   stop_flush,
    input  logic                   done,
    input  logic                   clear,
    input  logic                   end_test,
    input  int                     test_id,
    input  logic                   port16,
    input  dma_bus_pkg::bus_addr_t base,
    input  int                     exp_writes,
    input  logic                   exp_done,
    input  int                     exp_flushes,
    input  logic                   exp_idle,
    output int                     tests_run,
    output int                     tests_failed
);
    import dma_bus_pkg::*;

    bus_data_t pushed [$];
    int        writes;
    int        credits;
    int        flushes;
    int        errors;
    logic      as_q;

    // expected {addr, data} of write number idx in a transfer
    function automatic logic [63:0] expected_write(input bus_addr_t start, input bus_data_t word,
                                                   input int idx, input logic half_port);
        bus_addr_t a;
        bus_data_t d;
        if (half_port) begin
            a = start + 32'(4 * (idx / 2) + 2 * (idx % 2));
            d = (idx % 2 == 1) ? {word[15:0], 16'h0} : {word[31:16], 16'h0};
        end else begin
            a = start + 32'(4 * idx);
            d = word;
        end
        return {a, d};
    endfunction

    initial begin
        writes       = 0;
        credits      = 0;
        flushes      = 0;
        errors       = 0;
        as_q         = 1'b0;
        tests_run    = 0;
        tests_failed = 0;
    end

    always @(posedge BCLK) begin
        if (clear) begin
            pushed.delete();
            writes  = 0;
            credits = 0;
            flushes = 0;
            errors  = 0;
        end else if (CCRESET_) begin
            if (dev_valid) begin
                pushed.push_back(dev_data);
            end
            if (dev_credit) begin
                credits++;
            end
            if (stop_flush) begin
                flushes++;
            end
        end
        if (end_test) begin
            if (writes != exp_writes) begin
                $display("test %0d: %0d bus writes seen where %0d were expected",
                         test_id, writes, exp_writes);
                errors++;
            end
            if (credits != pushed.size()) begin
                $display("test %0d: %0d credits came back for %0d words sent",
                         test_id, credits, pushed.size());
                errors++;
            end
            if (flushes != exp_flushes) begin
                $display("test %0d: %0d stop_flush pulses where %0d were expected",
                         test_id, flushes, exp_flushes);
                errors++;
            end
            if (done !== exp_done) begin
                $display("Mismatch at %0t: done is %b, expected %b", $time, done, exp_done);
                errors++;
            end
            if (exp_idle && ((br | bgack | as | ds | stop_flush | dev_credit) !== 1'b0)) begin
                $display("test %0d: bus or status outputs active after reset", test_id);
                errors++;
            end
            tests_run++;
            if (errors == 0) begin
                $display("test %0d: pass, %0d writes", test_id, writes);
            end else begin
                $display("test %0d: failed with %0d errors", test_id, errors);
                tests_failed++;
            end
        end
    end

    // as drops on the edge that completes a write while addr and data still hold
    always @(negedge BCLK) begin : compare_writes
        logic [63:0] exp;
        bus_data_t   got;
        int          idx;
        if (CCRESET_ && as_q && !as) begin
            idx = port16 ? writes / 2 : writes;
            if (done !== 1'b0) begin
                $display("bus write at %0t completed while done was already high", $time);
                errors++;
            end
            if (idx >= pushed.size()) begin
                $display("bus write at %0t to %h has no device word behind it", $time, addr);
                errors++;
            end else begin
                exp = expected_write(base, pushed[idx], writes, port16);
                got = port16 ? {data_out[31:16], 16'h0} : data_out;
                if (addr !== exp[63:32]) begin
                    $display("Mismatch at %0t: addr is %h, expected %h",
                             $time, addr, exp[63:32]);
                    errors++;
                end
                if (got !== exp[31:0]) begin
                    $display("Mismatch at %0t: data_out is %h, expected %h",
                             $time, got, exp[31:0]);
                    errors++;
                end
            end
            writes++;
        end
        as_q = as;
    end

endmodule

// ==== test/tb_dma_top.sv ====
// testbench for dma_top: credit-based device producer, bus arbiter and memory responder
// the responder ends each strobe after 1 to 4 clocks, using the port type of the current test
`timescale 1ns/1ps

module tb_dma_top;
    import dma_bus_pkg::*;
    import dma_xfer_pkg::*;

    localparam int         CLK_PERIOD     = 20;
    localparam int         TOTAL_WORDS    = 16 + 16 + 6 + 24 + 3;
    localparam int         TIMEOUT_CYCLES = TOTAL_WORDS * 40 + 1000;
    localparam logic [1:0] MODE_32        = 2'd0;
    localparam logic [1:0] MODE_STERM     = 2'd1;
    localparam logic [1:0] MODE_16        = 2'd2;

    logic      BCLK;
    logic      CCRESET_;
    logic      load;
    bus_addr_t start_addr;
    word_cnt_t word_count;
    logic      dma_ena;
    logic      flush;
    logic      dev_valid;
    bus_data_t dev_data;
    logic      dev_credit;
    logic      br;
    logic      bg_;
    logic      bgack;
    logic      as;
    logic      ds;
    bus_addr_t addr;
    bus_data_t data_out;
    term_t     dsack_;
    logic      sterm_;
    logic      stop_flush;
    logic      done;

    integer     seed;
    int         credits;
    int         to_send;
    int         resp_delay;
    logic [1:0] mode;
    logic       clear;
    logic       end_test;
    int         test_id;
    bus_addr_t  base;
    int         exp_writes;
    logic       exp_done;
    int         exp_flushes;
    logic       exp_idle;
    int         tests_run;
    int         tests_failed;

    dma_top dut (
        .BCLK       (BCLK),
        .CCRESET_   (CCRESET_),
        .load       (load),
        .start_addr (start_addr),
        .word_count (word_count),
        .dma_ena    (dma_ena),
        .flush      (flush),
        .dev_valid  (dev_valid),
        .dev_data   (dev_data),
        .dev_credit (dev_credit),
        .br         (br),
        .bg_        (bg_),
        .bgack      (bgack),
        .as         (as),
        .ds         (ds),
        .addr       (addr),
        .data_out   (data_out),
        .dsack_     (dsack_),
        .sterm_     (sterm_),
        .stop_flush (stop_flush),
        .done       (done)
    );

    tb_dma_checker u_check (
        .BCLK         (BCLK),
        .CCRESET_     (CCRESET_),
        .dev_valid    (dev_valid),
        .dev_data     (dev_data),
        .dev_credit   (dev_credit),
        .br           (br),
        .bgack        (bgack),
        .as           (as),
        .ds           (ds),
        .addr         (addr),
        .data_out     (data_out),
        .stop_flush   (stop_flush),
        .done         (done),
        .clear        (clear),
        .end_test     (end_test),
        .test_id      (test_id),
        .port16       (mode == MODE_16),
        .base         (base),
        .exp_writes   (exp_writes),
        .exp_done     (exp_done),
        .exp_flushes  (exp_flushes),
        .exp_idle     (exp_idle),
        .tests_run    (tests_run),
        .tests_failed (tests_failed)
    );

    always #(CLK_PERIOD / 2) BCLK = ~BCLK;

    // device side: never sends without a credit in hand
    always @(negedge BCLK) begin
        if (!CCRESET_) begin
            credits   = FIFO_DEPTH;
            dev_valid = 1'b0;
        end else begin
            if (dev_valid) begin
                credits = credits - 1;
            end
            if (dev_credit) begin
                credits = credits + 1;
            end
            if (to_send > 0 && credits > 0) begin
                dev_valid = 1'b1;
                dev_data  = $random(seed);
                to_send   = to_send - 1;
            end else begin
                dev_valid = 1'b0;
            end
        end
    end

    // arbiter grants whenever br is up, memory answers each strobe after a random delay
    always @(negedge BCLK) begin
        bg_ = !br;
        if (!as) begin
            dsack_     = TERM_WAIT;
            sterm_     = 1'b1;
            resp_delay = -1;
        end else if (resp_delay < 0) begin
            resp_delay = 1 + ($unsigned($random(seed)) % 4);
        end else if (resp_delay > 0) begin
            resp_delay = resp_delay - 1;
            if (resp_delay == 0) begin
                case (mode)
                    MODE_16:    dsack_ = TERM_16;
                    MODE_STERM: sterm_ = 1'b0;
                    default:    dsack_ = TERM_32;
                endcase
            end
        end
    end

    task automatic start_test(input int id, input logic [1:0] m, input bus_addr_t a,
                              input int words);
        @(negedge BCLK);
        test_id    = id;
        mode       = m;
        base       = a;
        clear      = 1'b1;
        load       = 1'b1;
        start_addr = a;
        word_count = word_cnt_t'(words);
        @(negedge BCLK);
        clear   = 1'b0;
        load    = 1'b0;
        dma_ena = 1'b1;
        repeat (3) @(negedge BCLK);
    endtask

    task automatic finish_test(input int writes, input logic d, input int flushes,
                               input logic idle);
        while (bgack) begin
            @(negedge BCLK);
        end
        repeat (4) @(negedge BCLK);
        dma_ena     = 1'b0;
        exp_writes  = writes;
        exp_done    = d;
        exp_flushes = flushes;
        exp_idle    = idle;
        end_test    = 1'b1;
        @(negedge BCLK);
        end_test = 1'b0;
    endtask

    task automatic wait_done;
        while (!done) begin
            @(negedge BCLK);
        end
    endtask

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: tests still running after %0d clock cycles", TIMEOUT_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        seed        = 32'h6218;
        BCLK        = 1'b0;
        CCRESET_    = 1'b0;
        load        = 1'b0;
        start_addr  = '0;
        word_count  = '0;
        dma_ena     = 1'b0;
        flush       = 1'b0;
        dev_valid   = 1'b0;
        dev_data    = '0;
        bg_         = 1'b1;
        dsack_      = TERM_WAIT;
        sterm_      = 1'b1;
        to_send     = 0;
        resp_delay  = -1;
        mode        = MODE_32;
        clear       = 1'b0;
        end_test    = 1'b0;
        test_id     = 1;
        base        = '0;
        exp_writes  = 0;
        exp_done    = 1'b0;
        exp_flushes = 0;
        exp_idle    = 1'b0;
        repeat (5) @(negedge BCLK);
        CCRESET_ = 1'b1;
        repeat (2) @(negedge BCLK);
        finish_test(0, 1'b0, 0, 1'b1);

        start_test(2, MODE_32, 32'h0000_1000, 16);
        to_send = 16;
        wait_done();
        finish_test(16, 1'b1, 0, 1'b0);

        start_test(3, MODE_STERM, 32'h0000_1000, 16);
        to_send = 16;
        wait_done();
        finish_test(16, 1'b1, 0, 1'b0);

        // two bus cycles per word
        start_test(4, MODE_16, 32'h0002_0000, 6);
        to_send = 6;
        wait_done();
        finish_test(12, 1'b1, 0, 1'b0);

        // three times the FIFO depth, the producer has to wait on credits
        start_test(5, MODE_32, 32'h0003_0100, 24);
        to_send = 24;
        wait_done();
        finish_test(24, 1'b1, 0, 1'b0);

        // below the burst threshold, only the flush gets these out
        start_test(6, MODE_32, 32'h0004_0000, 10);
        to_send = 3;
        while (to_send != 0) begin
            @(negedge BCLK);
        end
        repeat (4) @(negedge BCLK);
        flush = 1'b1;
        while (!stop_flush) begin
            @(negedge BCLK);
        end
        flush = 1'b0;
        finish_test(3, 1'b0, 1, 1'b0);

        repeat (2) @(negedge BCLK);
        $display("tests run: %0d, failed: %0d", tests_run, tests_failed);
        if (tests_failed == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
rtl/dma_bus_pkg.sv
rtl/dma_xfer_pkg.sv
rtl/cpu_bus_sync.sv
rtl/dma_fifo.sv
rtl/dma_addr_cnt.sv
rtl/cpu_sm.sv
rtl/dma_top.sv
test/tb_dma_checker.sv
test/tb_dma_top.sv
